// File: source/ooo_pkg.sv
package ooo_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////////////////////////
    localparam int XLEN          = 32;    // Data word
    localparam int OP_W          = 3;     // Opcode field
    localparam int MAX_ROB_TAG_W = 8;     // Widest tag an operand word can carry

    //////////////////////////////////////////////////////////////////////
    // Simple integer unit opcodes
    //////////////////////////////////////////////////////////////////////
    localparam logic [OP_W-1:0] OP_ADD = 3'd0;
    localparam logic [OP_W-1:0] OP_SUB = 3'd1;
    localparam logic [OP_W-1:0] OP_AND = 3'd2;
    localparam logic [OP_W-1:0] OP_OR  = 3'd3;
    localparam logic [OP_W-1:0] OP_XOR = 3'd4;
    localparam logic [OP_W-1:0] OP_SLT = 3'd5;    // Signed compare, result 1 or 0

    // Operand word, decoded by the ready bit next to it
    // Ready: the value itself
    // Not ready: ROB slot of the producer in the low bits
    typedef union packed {
        logic [XLEN-1:0] data;
        struct packed {
            logic [XLEN-MAX_ROB_TAG_W-1:0] pad;   // Zero above the tag
            logic [MAX_ROB_TAG_W-1:0]      tag;   // Producer ROB slot
        } prod;
    } operand_u;

endpackage

// File: source/dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit import ooo_pkg::*; #(
    parameter  int NUM_RS    = 4,
    parameter  int ROB_DEPTH = 8,
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // Upstream instruction
    input  logic                 dispatch_valid,
    input  logic [OP_W-1:0]      dispatch_op,
    input  logic                 src1_ready,
    input  operand_u             src1,
    input  logic                 src2_ready,
    input  operand_u             src2,
    // Station status and ROB tail
    input  logic [NUM_RS-1:0]    rs_busy,
    input  logic [ROB_TAG_W-1:0] alloc_tag,
    // ROB lookups for waiting operands
    input  logic                 lookup1_done,
    input  logic [XLEN-1:0]      lookup1_value,
    input  logic                 lookup2_done,
    input  logic [XLEN-1:0]      lookup2_value,
    // Result broadcast
    input  logic                 bcast_valid,
    input  logic [ROB_TAG_W-1:0] bcast_tag,
    input  logic [XLEN-1:0]      bcast_value,
    // Entry load
    output logic [NUM_RS-1:0]    rs_load,
    output logic                 alloc,
    output logic [ROB_TAG_W-1:0] lookup1_tag,
    output logic [ROB_TAG_W-1:0] lookup2_tag,
    output logic [OP_W-1:0]      ld_op,
    output operand_u             ld_src1,
    output logic                 ld_src1_ready,
    output operand_u             ld_src2,
    output logic                 ld_src2_ready,
    output logic [ROB_TAG_W-1:0] ld_tag
);

    logic [NUM_RS-1:0] free;
    logic [NUM_RS-1:0] pick;
    logic              hit1, hit2;

    // Returns {ready, word}; finished ROB slot first, then same-cycle broadcast
    function automatic logic [XLEN:0] resolve(input logic rdy, input operand_u src,
                                              input logic done, input logic [XLEN-1:0] value,
                                              input logic hit);
        if (rdy)  return {1'b1, src.data};
        if (done) return {1'b1, value};        // Producer already written back
        if (hit)  return {1'b1, bcast_value};  // Producer finishing right now
        return {1'b0, src.data};               // Still waiting, keep the tag
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Entry selection, lowest free entry wins
    //////////////////////////////////////////////////////////////////////
    assign free    = ~rs_busy;
    assign pick    = free & (~free + 1'b1);                 // Isolate lowest set bit
    assign rs_load = dispatch_valid ? pick : '0;
    assign alloc   = dispatch_valid && (|free);             // One ROB slot per dispatch

    // Waiting operands look up their producer slot
    assign lookup1_tag = src1.prod.tag[ROB_TAG_W-1:0];
    assign lookup2_tag = src2.prod.tag[ROB_TAG_W-1:0];
    assign hit1        = bcast_valid && (bcast_tag == lookup1_tag);
    assign hit2        = bcast_valid && (bcast_tag == lookup2_tag);

    // Shared payload to all entries
    assign ld_op  = dispatch_op;
    assign ld_tag = alloc_tag;   // Tail slot becomes this instruction's tag
    assign {ld_src1_ready, ld_src1} = resolve(src1_ready, src1, lookup1_done, lookup1_value, hit1);
    assign {ld_src2_ready, ld_src2} = resolve(src2_ready, src2, lookup2_done, lookup2_value, hit2);

    // Source must hold an RS credit, so some entry is free
    a_dispatch_credit: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_valid |-> !(&rs_busy));

endmodule

// File: source/rs_entry.sv
`timescale 1ns/1ps

module rs_entry import ooo_pkg::*; #(
    parameter  int ROB_DEPTH = 8,
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // Load from dispatcher
    input  logic                 load,
    input  logic [OP_W-1:0]      ld_op,
    input  operand_u             ld_src1,
    input  logic                 ld_src1_ready,
    input  operand_u             ld_src2,
    input  logic                 ld_src2_ready,
    input  logic [ROB_TAG_W-1:0] ld_tag,
    // Issue grant
    input  logic                 grant,
    // Result broadcast
    input  logic                 bcast_valid,
    input  logic [ROB_TAG_W-1:0] bcast_tag,
    input  logic [XLEN-1:0]      bcast_value,
    // Status and contents
    output logic                 busy,
    output logic                 req,
    output logic [OP_W-1:0]      op,
    output operand_u             src1,
    output operand_u             src2,
    output logic [ROB_TAG_W-1:0] tag
);

    logic rdy1, rdy2;     // Operand holds data, not a tag
    logic wake1, wake2;

    // Broadcast matches a waiting operand
    assign wake1 = busy && !rdy1 && bcast_valid && (src1.prod.tag[ROB_TAG_W-1:0] == bcast_tag);
    assign wake2 = busy && !rdy2 && bcast_valid && (src2.prod.tag[ROB_TAG_W-1:0] == bcast_tag);

    assign req = busy && rdy1 && rdy2;   // Both operands in hand

    //////////////////////////////////////////////////////////////////////
    // Entry state
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            rdy1 <= 1'b0;
            rdy2 <= 1'b0;
        end else if (load) begin                 // Only ever loaded while free
            busy <= 1'b1;
            rdy1 <= ld_src1_ready;
            rdy2 <= ld_src2_ready;
        end else begin
            if (grant) busy <= 1'b0;             // Issued, entry free next cycle
            if (wake1) rdy1 <= 1'b1;
            if (wake2) rdy2 <= 1'b1;
        end
    end

    // Instruction payload
    always_ff @(posedge clk) begin
        if (load) begin
            op   <= ld_op;
            src1 <= ld_src1;
            src2 <= ld_src2;
            tag  <= ld_tag;
        end
        if (wake1) src1.data <= bcast_value;     // Tag view replaced by the value
        if (wake2) src2.data <= bcast_value;
    end

    // Dispatcher only loads free entries, issue only grants busy ones
    a_load_grant: assert property (@(posedge clk) disable iff (!rst_n) !(load && grant));

endmodule

// File: source/issue_alu.sv
`timescale 1ns/1ps

module issue_alu import ooo_pkg::*; #(
    parameter  int NUM_RS    = 4,
    parameter  int ROB_DEPTH = 8,
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH),
    localparam int IDX_W     = (NUM_RS > 1) ? $clog2(NUM_RS) : 1
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // From the station entries
    input  logic [NUM_RS-1:0]                 req,
    input  logic [NUM_RS-1:0][OP_W-1:0]       entry_op,
    input  operand_u [NUM_RS-1:0]             entry_src1,
    input  operand_u [NUM_RS-1:0]             entry_src2,
    input  logic [NUM_RS-1:0][ROB_TAG_W-1:0]  entry_tag,
    // Grant back to the entries
    output logic [NUM_RS-1:0]                 grant,
    output logic                              rs_credit,
    // Result broadcast
    output logic                              bcast_valid,
    output logic [ROB_TAG_W-1:0]              bcast_tag,
    output logic [XLEN-1:0]                   bcast_value
);

    logic [IDX_W-1:0] last_q;   // Last granted entry
    logic [IDX_W-1:0] sel;
    logic             found;
    logic             fire_q;   // Result register holds a fresh result
    logic [XLEN-1:0]  a, b, result;

    //////////////////////////////////////////////////////////////////////
    // Rotating select, search starts just after the last grant
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        grant = '0;
        sel   = last_q;
        found = 1'b0;
        for (int i = 1; i <= NUM_RS; i++) begin
            if (!found && req[(int'(last_q) + i) % NUM_RS]) begin
                found = 1'b1;
                sel   = IDX_W'((int'(last_q) + i) % NUM_RS);
            end
        end
        if (found) grant[sel] = 1'b1;
    end

    // Single stage integer ALU
    assign a = entry_src1[sel].data;
    assign b = entry_src2[sel].data;

    always_comb begin
        case (entry_op[sel])
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fire_q <= 1'b0;
            last_q <= IDX_W'(NUM_RS - 1);   // First search begins at entry 0
        end else begin
            fire_q <= found;
            if (found) last_q <= sel;
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (found) begin
            bcast_tag   <= entry_tag[sel];
            bcast_value <= result;
        end
    end

    assign bcast_valid = fire_q;
    assign rs_credit   = fire_q;   // Entry freed at the grant edge

    // Granted entry is freed at the grant edge so its tag never issues twice in a row
    a_no_reissue: assert property (@(posedge clk) disable iff (!rst_n)
        found && bcast_valid |-> entry_tag[sel] != bcast_tag);

endmodule

// File: source/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; #(
    parameter  int ROB_DEPTH = 8,
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // Allocation from dispatcher
    input  logic                 alloc,
    output logic [ROB_TAG_W-1:0] alloc_tag,
    // Operand lookups at dispatch
    input  logic [ROB_TAG_W-1:0] lookup1_tag,
    input  logic [ROB_TAG_W-1:0] lookup2_tag,
    output logic                 lookup1_done,
    output logic [XLEN-1:0]      lookup1_value,
    output logic                 lookup2_done,
    output logic [XLEN-1:0]      lookup2_value,
    // Result broadcast
    input  logic                 bcast_valid,
    input  logic [ROB_TAG_W-1:0] bcast_tag,
    input  logic [XLEN-1:0]      bcast_value,
    // In-order retire
    output logic                 retire_valid,
    output logic [ROB_TAG_W-1:0] retire_tag,
    output logic [XLEN-1:0]      retire_value,
    output logic                 rob_credit
);

    logic [ROB_TAG_W-1:0] head, tail;
    logic [ROB_DEPTH-1:0] busy;                  // Slot allocated
    logic [ROB_DEPTH-1:0] done;                  // Result written
    logic [XLEN-1:0]      value_mem [ROB_DEPTH];

    assign alloc_tag = tail;   // Next tag in dispatch order

    // Lookups read the current state, same-cycle broadcast is the dispatcher's job
    assign lookup1_done  = done[lookup1_tag];
    assign lookup1_value = value_mem[lookup1_tag];
    assign lookup2_done  = done[lookup2_tag];
    assign lookup2_value = value_mem[lookup2_tag];

    //////////////////////////////////////////////////////////////////////
    // Retire, one per cycle from the head
    //////////////////////////////////////////////////////////////////////
    assign retire_valid = busy[head] && done[head];
    assign retire_tag   = head;
    assign retire_value = value_mem[head];
    assign rob_credit   = retire_valid;          // Slot returned as it leaves

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            busy <= '0;
            done <= '0;
        end else begin
            if (retire_valid) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= head + 1'b1;       // Wraps, depth is a power of two
            end
            if (alloc) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            if (bcast_valid) done[bcast_tag] <= 1'b1;
        end
    end

    // Result storage
    always_ff @(posedge clk) begin
        if (bcast_valid) value_mem[bcast_tag] <= bcast_value;
    end

    // Results only come back for live slots
    a_bcast_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        bcast_valid |-> busy[bcast_tag]);
    // ROB credits keep the tail off live slots
    a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> !busy[tail]);

endmodule

// File: source/ooo_core.sv
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; #(
    parameter  int NUM_RS    = 4,
    parameter  int ROB_DEPTH = 8,
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // Dispatch side
    input  logic                 dispatch_valid,
    input  logic [OP_W-1:0]      dispatch_op,
    input  logic                 src1_ready,
    input  operand_u             src1,
    input  logic                 src2_ready,
    input  operand_u             src2,
    output logic                 rs_credit,      // One pulse per freed entry
    output logic                 rob_credit,     // One pulse per retired slot
    // Retire side
    output logic                 retire_valid,
    output logic [ROB_TAG_W-1:0] retire_tag,
    output logic [XLEN-1:0]      retire_value
);

    // Dispatcher to entries
    logic [NUM_RS-1:0]                rs_busy, rs_load;
    logic [OP_W-1:0]                  ld_op;
    operand_u                         ld_src1, ld_src2;
    logic                             ld_src1_ready, ld_src2_ready;
    logic [ROB_TAG_W-1:0]             ld_tag;
    // Dispatcher to ROB
    logic                             alloc;
    logic [ROB_TAG_W-1:0]             alloc_tag, lookup1_tag, lookup2_tag;
    logic                             lookup1_done, lookup2_done;
    logic [XLEN-1:0]                  lookup1_value, lookup2_value;
    // Entries to issue
    logic [NUM_RS-1:0]                entry_req, grant;
    logic [NUM_RS-1:0][OP_W-1:0]      entry_op;
    operand_u [NUM_RS-1:0]            entry_src1, entry_src2;
    logic [NUM_RS-1:0][ROB_TAG_W-1:0] entry_tag;
    // Result broadcast
    logic                             bcast_valid;
    logic [ROB_TAG_W-1:0]             bcast_tag;
    logic [XLEN-1:0]                  bcast_value;

    dispatch_unit #(.NUM_RS(NUM_RS), .ROB_DEPTH(ROB_DEPTH)) u_dispatch (
        .clk, .rst_n, .dispatch_valid, .dispatch_op,
        .src1_ready, .src1, .src2_ready, .src2,
        .rs_busy, .alloc_tag,
        .lookup1_done, .lookup1_value, .lookup2_done, .lookup2_value,
        .bcast_valid, .bcast_tag, .bcast_value,
        .rs_load, .alloc, .lookup1_tag, .lookup2_tag,
        .ld_op, .ld_src1, .ld_src1_ready, .ld_src2, .ld_src2_ready, .ld_tag
    );

    //////////////////////////////////////////////////////////////////////
    // Reservation station, one entry per generate slot
    //////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_RS; i++) begin : g_rs
        rs_entry #(.ROB_DEPTH(ROB_DEPTH)) u_entry (
            .clk, .rst_n,
            .load(rs_load[i]), .ld_op, .ld_src1, .ld_src1_ready,
            .ld_src2, .ld_src2_ready, .ld_tag,
            .grant(grant[i]), .bcast_valid, .bcast_tag, .bcast_value,
            .busy(rs_busy[i]), .req(entry_req[i]), .op(entry_op[i]),
            .src1(entry_src1[i]), .src2(entry_src2[i]), .tag(entry_tag[i])
        );
    end

    issue_alu #(.NUM_RS(NUM_RS), .ROB_DEPTH(ROB_DEPTH)) u_issue (
        .clk, .rst_n, .req(entry_req), .entry_op, .entry_src1, .entry_src2, .entry_tag,
        .grant, .rs_credit, .bcast_valid, .bcast_tag, .bcast_value
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk, .rst_n, .alloc, .alloc_tag,
        .lookup1_tag, .lookup2_tag,
        .lookup1_done, .lookup1_value, .lookup2_done, .lookup2_value,
        .bcast_valid, .bcast_tag, .bcast_value,
        .retire_valid, .retire_tag, .retire_value, .rob_credit
    );

endmodule

// File: dv/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core import ooo_pkg::*; #(
    parameter int NUM_RS    = 4,
    parameter int ROB_DEPTH = 8
);

    localparam int ROB_TAG_W       = $clog2(ROB_DEPTH);
    localparam int N_INSTR         = 36 + 40 + 40 + 48;          // Sum over all tests
    localparam int WATCHDOG_CYCLES = N_INSTR * ROB_DEPTH * 20;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 dispatch_valid, src1_ready, src2_ready;
    logic [OP_W-1:0]      dispatch_op;
    operand_u             src1, src2;
    logic                 rs_credit, rob_credit, retire_valid;
    logic [ROB_TAG_W-1:0] retire_tag;
    logic [XLEN-1:0]      retire_value;

    // Reference model state, written only by the model block
    logic [ROB_TAG_W+XLEN-1:0] exp_q[$];                   // {tag, value} in dispatch order
    logic [XLEN-1:0]           model_val [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]      inflight = '0;               // Dispatched, not yet retired
    logic [ROB_TAG_W-1:0]      next_tag = '0, last_tag = '0;
    logic [ROB_TAG_W-1:0]      exp_head_tag = '0;
    logic [XLEN-1:0]           exp_head_val = '0, drv_val = '0;
    int                        rs_cred = NUM_RS, rob_cred = ROB_DEPTH;
    int                        exp_pending = 0, n_disp = 0, n_ret = 0;
    logic                      started = 1'b0;
    int                        assert_errors = 0, end_errors = 0;
    int                        tests_run = 0, tests_failed = 0, err0;
    integer                    seed = 87;

    ooo_core #(.NUM_RS(NUM_RS), .ROB_DEPTH(ROB_DEPTH)) dut (
        .clk, .rst_n, .dispatch_valid, .dispatch_op,
        .src1_ready, .src1, .src2_ready, .src2,
        .rs_credit, .rob_credit, .retire_valid, .retire_tag, .retire_value
    );

    always #4 clk = ~clk;   // 8 ns period

    // Opcode rules, SLT as signed compare
    function automatic logic [XLEN-1:0] expected_result(input logic [OP_W-1:0] op,
                                                         input logic [XLEN-1:0] a,
                                                         input logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
            default: return '0;
        endcase
    endfunction

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic int error_total();
        return assert_errors + end_errors;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model, follows dispatches, credits and retires
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk or negedge rst_n) begin
        logic [ROB_TAG_W+XLEN-1:0] popped;
        if (!rst_n) begin
            rs_cred  = NUM_RS;
            rob_cred = ROB_DEPTH;
        end else begin
            if (rs_credit) rs_cred++;
            if (rob_credit) rob_cred++;
            if (retire_valid && exp_q.size() > 0) begin
                popped = exp_q.pop_front();
                inflight[popped[XLEN +: ROB_TAG_W]] = 1'b0;
                n_ret++;
            end
            if (dispatch_valid) begin
                rs_cred--;
                rob_cred--;
                exp_q.push_back({next_tag, drv_val});
                model_val[next_tag] = drv_val;   // Value forwarded to later consumers
                inflight[next_tag]  = 1'b1;
                last_tag            = next_tag;
                next_tag++;
                n_disp++;
                started = 1'b1;
            end
            exp_pending = exp_q.size();
            if (exp_pending > 0) {exp_head_tag, exp_head_val} = exp_q[0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Concurrent checks
    //////////////////////////////////////////////////////////////////////
    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !(rs_credit || rob_credit || retire_valid))
        else begin
            assert_errors++;
            $display("MISMATCH at %0t: credit or retire pulse before first dispatch", $time);
        end

    retire_order: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (exp_pending > 0) && (retire_tag == exp_head_tag))
        else begin
            assert_errors++;
            $display("MISMATCH at %0t: retire tag %0d, expected %0d", $time,
                     retire_tag, exp_head_tag);
        end

    retire_data: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_value == exp_head_val)
        else begin
            assert_errors++;
            $display("MISMATCH at %0t: retire value %h, expected %h", $time,
                     retire_value, exp_head_val);
        end

    credit_bounds: assert property (@(posedge clk) disable iff (!rst_n)
        rs_cred >= 0 && rs_cred <= NUM_RS && rob_cred >= 0 && rob_cred <= ROB_DEPTH)
        else begin
            assert_errors++;
            $display("MISMATCH at %0t: credits rs %0d rob %0d out of range", $time,
                     rs_cred, rob_cred);
        end

    //////////////////////////////////////////////////////////////////////
    // Stimulus, called at a falling edge
    //////////////////////////////////////////////////////////////////////
    task automatic send(input int op_sel, input int dep_pct, input int gap_max);
        logic [XLEN-1:0] a, b;
        int              t;
        while (rs_cred == 0 || rob_cred == 0) @(negedge clk);   // Wait for credits
        dispatch_op = (op_sel < 0) ? OP_W'(rand_below(6)) : OP_W'(op_sel);
        a = $random(seed);
        b = $random(seed);
        src1_ready = 1'b1;
        src1.data  = a;
        src2_ready = 1'b1;
        src2.data  = b;
        if (inflight[last_tag] && rand_below(100) < dep_pct) begin   // Chain on newest
            src1_ready    = 1'b0;
            src1          = '0;
            src1.prod.tag = MAX_ROB_TAG_W'(last_tag);
            a             = model_val[last_tag];
        end
        t = rand_below(ROB_DEPTH);
        if (inflight[t] && rand_below(100) < dep_pct) begin          // Any live producer
            src2_ready    = 1'b0;
            src2          = '0;
            src2.prod.tag = MAX_ROB_TAG_W'(t);
            b             = model_val[t];
        end
        drv_val        = expected_result(dispatch_op, a, b);
        dispatch_valid = 1'b1;
        @(negedge clk);
        dispatch_valid = 1'b0;
        repeat (rand_below(gap_max + 1)) @(negedge clk);
    endtask

    // Let the pipeline empty, then every credit must be back
    task automatic drain();
        while (exp_pending != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        assert (rs_cred == NUM_RS && rob_cred == ROB_DEPTH && n_ret == n_disp)
            else begin
                end_errors++;
                $display("After drain: rs credits %0d, rob credits %0d, %0d of %0d retired",
                         rs_cred, rob_cred, n_ret, n_disp);
            end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (error_total() == err_before) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, error_total() - err_before);
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = OP_ADD;
        src1_ready     = 1'b1;
        src1           = '0;
        src2_ready     = 1'b1;
        src2           = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        err0 = error_total();
        repeat (10) @(negedge clk);   // Idle, outputs must stay quiet
        report_test("reset_quiet", err0);

        err0 = error_total();
        for (int i = 0; i < 36; i++) send(i % 6, 0, 1);
        drain();
        report_test("independent_ops", err0);

        err0 = error_total();
        for (int i = 0; i < 40; i++) send(-1, (i % 2 == 0) ? 100 : 0, 0);
        drain();
        report_test("out_of_order_issue", err0);

        err0 = error_total();
        for (int i = 0; i < 40; i++) send(-1, 100, 2);
        drain();
        report_test("dependency_chain", err0);

        err0 = error_total();
        for (int i = 0; i < 48; i++) send(-1, 70, 0);   // Back to back until credits run out
        drain();
        report_test("credit_exhaustion", err0);

        $display("Summary: %0d tests, %0d failed, %0d errors, %0d dispatched, %0d retired",
                 tests_run, tests_failed, error_total(), n_disp, n_ret);
        if (error_total() == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the pipeline did not drain",
                 WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: all.f
source/ooo_pkg.sv
source/dispatch_unit.sv
source/rs_entry.sv
source/issue_alu.sv
source/reorder_buffer.sv
source/ooo_core.sv
dv/tb_ooo_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
